//--- cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;
    typedef logic [5:0] opcodeT;

    // Primary opcodes
    localparam opcodeT opSpecial = 6'h00;
    localparam opcodeT opJ = 6'h02;
    localparam opcodeT opJal = 6'h03;
    localparam opcodeT opBeq = 6'h04;
    localparam opcodeT opBne = 6'h05;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opOri = 6'h0d;
    localparam opcodeT opLui = 6'h0f;
    localparam opcodeT opLw = 6'h23;
    localparam opcodeT opSw = 6'h2b;

    // Function codes of R-type instructions
    localparam opcodeT fnJr = 6'h08;
    localparam opcodeT fnAddu = 6'h21;
    localparam opcodeT fnSubu = 6'h23;
    localparam opcodeT fnAnd = 6'h24;
    localparam opcodeT fnOr = 6'h25;
    localparam opcodeT fnSlt = 6'h2a;

    localparam wordT resetPc = 32'h0000_0000;
    localparam wordT linkOffset = 32'd8;

    typedef enum logic [2:0] {aluNone, aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;
    typedef enum logic [1:0] {wbNone, wbAlu, wbLink, wbLoad} wbSourceT;
    typedef enum logic [2:0] {brNone, brEqual, brNotEqual, brJumpImm, brJumpReg} branchKindT;

    typedef struct packed {
        regAddrT src1;
        regAddrT src2;
        regAddrT dest;
        aluOpT aluOp;
        logic useImm;
        wordT imm;
        branchKindT branch;
        logic isLoad;
        logic isStore;
        wbSourceT wbSource;
    } decodedCtrlT;

    typedef struct packed {
        logic valid;
        wordT instr;
        wordT pc;
    } fetchPacketT;

    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT dest;
        logic isLoad;
        logic isStore;
        wbSourceT wbSource;
        wordT result;
        wordT storeData;
        wordT memAddr;
    } execPacketT;

    // Destination zero means nothing to forward
    typedef struct packed {
        logic ready;
        regAddrT dest;
        wordT value;
    } forwardSourceT;

    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT dest;
        wordT value;
    } wbPacketT;

endpackage

//--- fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input logic clk,
    input logic reset,
    input logic hold,
    input logic redirectValid,
    input cpuPkg::wordT redirectPc,
    input cpuPkg::wordT instRdata,
    input logic instValid,
    output cpuPkg::wordT instAddr,
    output logic instReadEn,
    output cpuPkg::fetchPacketT fetched
);

    cpuPkg::wordT pc;
    cpuPkg::wordT pendingPc;
    logic pendingValid;
    logic running;
    logic accept;
    cpuPkg::fetchPacketT heldWord;

    // No new request while a word waits for decode
    assign instAddr = pc;
    assign instReadEn = running && !heldWord.valid;
    assign accept = instReadEn && instValid;

    always_comb begin
        if (heldWord.valid) begin
            fetched = heldWord;
        end else begin
            fetched.valid = accept;
            fetched.instr = instRdata;
            fetched.pc = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pendingValid <= 1'b0;
            heldWord.valid <= 1'b0;
            pc <= cpuPkg::resetPc;
        end else begin
            running <= 1'b1;
            if (accept && hold) begin
                heldWord.valid <= 1'b1;
                heldWord.instr <= instRdata;
                heldWord.pc <= pc;
            end else if (!hold) begin
                heldWord.valid <= 1'b0;
            end
            if (accept) begin
                if (redirectValid) begin
                    pc <= redirectPc;
                end else if (pendingValid) begin
                    pc <= pendingPc;
                    pendingValid <= 1'b0;
                end else begin
                    pc <= pc + 32'd4;
                end
            end else if (redirectValid) begin
                // Delay slot already here, otherwise wait for it to land
                if (heldWord.valid) begin
                    pc <= redirectPc;
                end else begin
                    pendingValid <= 1'b1;
                    pendingPc <= redirectPc;
                end
            end
        end
    end

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input logic clk,
    input logic reset,
    input cpuPkg::regAddrT readAddr1,
    input cpuPkg::regAddrT readAddr2,
    input cpuPkg::regAddrT writeAddr,
    input cpuPkg::wordT writeData,
    output cpuPkg::wordT readData1,
    output cpuPkg::wordT readData2
);

    cpuPkg::wordT regs [1:31];

    // Address zero doubles as no write
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input logic clk,
    input logic reset,
    input cpuPkg::fetchPacketT fetched,
    input logic hold,
    input cpuPkg::wordT readData1,
    input cpuPkg::wordT readData2,
    input cpuPkg::forwardSourceT fwdExec,
    input cpuPkg::forwardSourceT fwdWb,
    output cpuPkg::regAddrT readAddr1,
    output cpuPkg::regAddrT readAddr2,
    output logic redirectValid,
    output cpuPkg::wordT redirectPc,
    output logic fetchHold,
    output cpuPkg::execPacketT issued
);

    cpuPkg::fetchPacketT current;
    cpuPkg::decodedCtrlT ctrl;
    cpuPkg::forwardSourceT operand1;
    cpuPkg::forwardSourceT operand2;
    cpuPkg::opcodeT opcode;
    cpuPkg::opcodeT funct;
    cpuPkg::regAddrT rs;
    cpuPkg::regAddrT rt;
    cpuPkg::regAddrT rd;
    cpuPkg::wordT immSigned;
    cpuPkg::wordT immZero;
    cpuPkg::wordT aluB;
    cpuPkg::wordT aluOut;
    cpuPkg::wordT pcPlus4;
    logic operandStall;
    logic taken;

    // Newest producer first; a match that is not ready stalls
    function automatic cpuPkg::forwardSourceT pickOperand(
        input cpuPkg::regAddrT src,
        input cpuPkg::wordT rfValue,
        input cpuPkg::forwardSourceT ex,
        input cpuPkg::forwardSourceT wb
    );
        cpuPkg::forwardSourceT pick;
        pick.dest = src;
        if (src != '0 && src == ex.dest) begin
            pick.ready = ex.ready;
            pick.value = ex.value;
        end else if (src != '0 && src == wb.dest) begin
            pick.ready = wb.ready;
            pick.value = wb.value;
        end else begin
            pick.ready = 1'b1;
            pick.value = rfValue;
        end
        return pick;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            current.valid <= 1'b0;
        end else if (!fetchHold) begin
            current <= fetched;
        end
    end

    assign opcode = current.instr[31:26];
    assign funct = current.instr[5:0];
    assign rs = current.instr[25:21];
    assign rt = current.instr[20:16];
    assign rd = current.instr[15:11];
    assign immSigned = {{16{current.instr[15]}}, current.instr[15:0]};
    assign immZero = {16'h0000, current.instr[15:0]};

    // Unused source fields stay zero so they never stall
    always_comb begin
        ctrl = '0;
        case (opcode)
            cpuPkg::opSpecial: begin
                ctrl.src1 = rs;
                ctrl.src2 = rt;
                ctrl.dest = rd;
                ctrl.wbSource = cpuPkg::wbAlu;
                case (funct)
                    cpuPkg::fnAddu: ctrl.aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: ctrl.aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd: ctrl.aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr: ctrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::fnSlt: ctrl.aluOp = cpuPkg::aluSlt;
                    cpuPkg::fnJr: begin
                        ctrl.src2 = '0;
                        ctrl.dest = '0;
                        ctrl.wbSource = cpuPkg::wbNone;
                        ctrl.branch = cpuPkg::brJumpReg;
                    end
                    default: ctrl = '0;
                endcase
            end
            cpuPkg::opAddiu, cpuPkg::opOri, cpuPkg::opLui, cpuPkg::opLw: begin
                ctrl.src1 = (opcode == cpuPkg::opLui) ? '0 : rs;
                ctrl.dest = rt;
                ctrl.useImm = 1'b1;
                ctrl.imm = (opcode == cpuPkg::opOri || opcode == cpuPkg::opLui) ? immZero
                                                                               : immSigned;
                ctrl.aluOp = (opcode == cpuPkg::opOri) ? cpuPkg::aluOr
                           : (opcode == cpuPkg::opLui) ? cpuPkg::aluLui : cpuPkg::aluAdd;
                ctrl.isLoad = (opcode == cpuPkg::opLw);
                ctrl.wbSource = (opcode == cpuPkg::opLw) ? cpuPkg::wbLoad : cpuPkg::wbAlu;
            end
            cpuPkg::opSw: begin
                ctrl.src1 = rs;
                ctrl.src2 = rt;
                ctrl.useImm = 1'b1;
                ctrl.imm = immSigned;
                ctrl.aluOp = cpuPkg::aluAdd;
                ctrl.isStore = 1'b1;
            end
            cpuPkg::opBeq, cpuPkg::opBne: begin
                ctrl.src1 = rs;
                ctrl.src2 = rt;
                ctrl.imm = immSigned;
                ctrl.branch = (opcode == cpuPkg::opBeq) ? cpuPkg::brEqual : cpuPkg::brNotEqual;
            end
            cpuPkg::opJ, cpuPkg::opJal: begin
                ctrl.imm = {6'b000000, current.instr[25:0]};
                ctrl.branch = cpuPkg::brJumpImm;
                if (opcode == cpuPkg::opJal) begin
                    ctrl.dest = 5'd31;
                    ctrl.wbSource = cpuPkg::wbLink;
                end
            end
            default: ctrl = '0;
        endcase
    end

    assign readAddr1 = ctrl.src1;
    assign readAddr2 = ctrl.src2;
    assign operand1 = pickOperand(ctrl.src1, readData1, fwdExec, fwdWb);
    assign operand2 = pickOperand(ctrl.src2, readData2, fwdExec, fwdWb);
    assign operandStall = current.valid && !(operand1.ready && operand2.ready);
    assign fetchHold = hold || operandStall;

    assign aluB = ctrl.useImm ? ctrl.imm : operand2.value;

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluAdd: aluOut = operand1.value + aluB;
            cpuPkg::aluSub: aluOut = operand1.value - aluB;
            cpuPkg::aluAnd: aluOut = operand1.value & aluB;
            cpuPkg::aluOr: aluOut = operand1.value | aluB;
            cpuPkg::aluSlt: aluOut = {31'b0, $signed(operand1.value) < $signed(aluB)};
            cpuPkg::aluLui: aluOut = {aluB[15:0], 16'h0000};
            default: aluOut = '0;
        endcase
    end

    assign pcPlus4 = current.pc + 32'd4;

    always_comb begin
        taken = 1'b0;
        redirectPc = pcPlus4;
        case (ctrl.branch)
            cpuPkg::brEqual, cpuPkg::brNotEqual: begin
                taken = (operand1.value == operand2.value) == (ctrl.branch == cpuPkg::brEqual);
                redirectPc = pcPlus4 + {ctrl.imm[29:0], 2'b00};
            end
            cpuPkg::brJumpImm: begin
                taken = 1'b1;
                redirectPc = {pcPlus4[31:28], ctrl.imm[25:0], 2'b00};
            end
            cpuPkg::brJumpReg: begin
                taken = 1'b1;
                redirectPc = operand1.value;
            end
            default: taken = 1'b0;
        endcase
    end

    assign redirectValid = current.valid && taken && !fetchHold;

    always_comb begin
        issued.valid = current.valid && !operandStall;
        issued.pc = current.pc;
        issued.dest = ctrl.dest;
        issued.isLoad = ctrl.isLoad;
        issued.isStore = ctrl.isStore;
        issued.wbSource = ctrl.wbSource;
        issued.result = (ctrl.wbSource == cpuPkg::wbLink) ? current.pc + cpuPkg::linkOffset
                                                          : aluOut;
        issued.storeData = operand2.value;
        issued.memAddr = aluOut;
    end

endmodule

//--- executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input logic clk,
    input logic reset,
    input cpuPkg::execPacketT issued,
    input cpuPkg::wordT dataRdata,
    input logic dataValid,
    output cpuPkg::wordT dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output cpuPkg::wordT dataWdata,
    output logic hold,
    output cpuPkg::forwardSourceT fwdExec,
    output cpuPkg::wbPacketT result
);

    cpuPkg::execPacketT current;

    always_ff @(posedge clk) begin
        if (reset) begin
            current.valid <= 1'b0;
        end else if (!hold) begin
            current <= issued;
        end
    end

    // Request stays up until the memory answers
    assign dataRead = current.valid && current.isLoad;
    assign dataWrite = current.valid && current.isStore;
    assign dataAddr = current.memAddr;
    assign dataWdata = current.storeData;
    assign hold = (dataRead || dataWrite) && !dataValid;

    // Loads are announced but never ready here
    always_comb begin
        fwdExec.ready = current.valid
                      && (current.wbSource == cpuPkg::wbAlu || current.wbSource == cpuPkg::wbLink);
        if (current.valid && current.wbSource != cpuPkg::wbNone) begin
            fwdExec.dest = current.dest;
        end else begin
            fwdExec.dest = '0;
        end
        fwdExec.value = current.result;
    end

    always_comb begin
        result.valid = current.valid && !hold;
        result.pc = current.pc;
        result.dest = (current.wbSource != cpuPkg::wbNone) ? current.dest : '0;
        result.value = current.isLoad ? dataRdata : current.result;
    end

endmodule

//--- writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
    input logic clk,
    input logic reset,
    input cpuPkg::wbPacketT result,
    output cpuPkg::regAddrT writeAddr,
    output cpuPkg::wordT writeData,
    output cpuPkg::forwardSourceT fwdWb,
    output cpuPkg::wordT wbPc,
    output logic [3:0] wbWen,
    output cpuPkg::regAddrT wbNum,
    output cpuPkg::wordT wbData
);

    cpuPkg::wbPacketT current;
    logic writes;

    always_ff @(posedge clk) begin
        if (reset) begin
            current.valid <= 1'b0;
        end else begin
            current <= result;
        end
    end

    assign writes = current.valid && current.dest != '0;
    assign writeAddr = writes ? current.dest : '0;
    assign writeData = current.value;

    always_comb begin
        fwdWb.ready = writes;
        fwdWb.dest = writeAddr;
        fwdWb.value = current.value;
    end

    // Trace of every retired instruction
    assign wbPc = current.pc;
    assign wbWen = {4{writes}};
    assign wbNum = writeAddr;
    assign wbData = current.value;

endmodule

//--- cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input logic clk,
    input logic reset,
    output cpuPkg::wordT instAddr,
    output logic instReadEn,
    input cpuPkg::wordT instRdata,
    input logic instValid,
    output cpuPkg::wordT dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output cpuPkg::wordT dataWdata,
    input cpuPkg::wordT dataRdata,
    input logic dataValid,
    output cpuPkg::wordT wbPc,
    output logic [3:0] wbWen,
    output cpuPkg::regAddrT wbNum,
    output cpuPkg::wordT wbData
);

    cpuPkg::fetchPacketT fetched;
    cpuPkg::execPacketT issued;
    cpuPkg::wbPacketT result;
    cpuPkg::forwardSourceT fwdExec;
    cpuPkg::forwardSourceT fwdWb;
    cpuPkg::regAddrT readAddr1;
    cpuPkg::regAddrT readAddr2;
    cpuPkg::wordT readData1;
    cpuPkg::wordT readData2;
    cpuPkg::regAddrT writeAddr;
    cpuPkg::wordT writeData;
    cpuPkg::wordT redirectPc;
    logic redirectValid;
    logic hold;
    // Execute hold combined with the operand stall of decode
    logic fetchHold;

    fetchUnit fetch (
        .clk(clk),
        .reset(reset),
        .hold(fetchHold),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .instRdata(instRdata),
        .instValid(instValid),
        .instAddr(instAddr),
        .instReadEn(instReadEn),
        .fetched(fetched)
    );

    decodeStage decode (
        .clk(clk),
        .reset(reset),
        .fetched(fetched),
        .hold(hold),
        .readData1(readData1),
        .readData2(readData2),
        .fwdExec(fwdExec),
        .fwdWb(fwdWb),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .fetchHold(fetchHold),
        .issued(issued)
    );

    registerFile regs (
        .clk(clk),
        .reset(reset),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .readData1(readData1),
        .readData2(readData2)
    );

    executeStage execute (
        .clk(clk),
        .reset(reset),
        .issued(issued),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .hold(hold),
        .fwdExec(fwdExec),
        .result(result)
    );

    writebackStage writeback (
        .clk(clk),
        .reset(reset),
        .result(result),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .fwdWb(fwdWb),
        .wbPc(wbPc),
        .wbWen(wbWen),
        .wbNum(wbNum),
        .wbData(wbData)
    );

endmodule

//--- cpuCore_assertions.sv
`timescale 1ns/1ps

module cpuCoreAssertions (
    input logic clk,
    input logic reset,
    input cpuPkg::wordT instAddr,
    input logic instReadEn,
    input logic instValid,
    input cpuPkg::wordT dataAddr,
    input logic dataRead,
    input logic dataWrite,
    input cpuPkg::wordT dataWdata,
    input logic dataValid,
    input logic [3:0] wbWen,
    input cpuPkg::regAddrT wbNum
);

    int unsigned failCount = 0;

    instHeld: assert property (@(posedge clk) disable iff (reset)
        instReadEn && !instValid |=> instReadEn && $stable(instAddr))
        else begin
            failCount++;
            $error("Instruction request changed before instValid");
        end

    dataHeld: assert property (@(posedge clk) disable iff (reset)
        (dataRead || dataWrite) && !dataValid |=>
            $stable(dataRead) && $stable(dataWrite) && $stable(dataAddr))
        else begin
            failCount++;
            $error("Data request changed before dataValid");
        end

    storeDataHeld: assert property (@(posedge clk) disable iff (reset)
        dataWrite && !dataValid |=> $stable(dataWdata))
        else begin
            failCount++;
            $error("Store data changed before dataValid");
        end

    oneDataOp: assert property (@(posedge clk) disable iff (reset) !(dataRead && dataWrite))
        else begin
            failCount++;
            $error("dataRead and dataWrite high together");
        end

    noZeroWrite: assert property (@(posedge clk) disable iff (reset)
        wbWen != 4'h0 |-> wbNum != '0)
        else begin
            failCount++;
            $error("Write to register zero reported");
        end

    // Covers every reset cycle and the first cycle after it
    quietAfterReset: assert property (@(posedge clk)
        reset |=> !instReadEn && !dataRead && !dataWrite && wbWen == 4'h0)
        else begin
            failCount++;
            $error("Control outputs active in or right after reset");
        end

endmodule

bind cpuCore cpuCoreAssertions protocolChecks (
    .clk(clk),
    .reset(reset),
    .instAddr(instAddr),
    .instReadEn(instReadEn),
    .instValid(instValid),
    .dataAddr(dataAddr),
    .dataRead(dataRead),
    .dataWrite(dataWrite),
    .dataWdata(dataWdata),
    .dataValid(dataValid),
    .wbWen(wbWen),
    .wbNum(wbNum)
);

//--- tbCpu.sv
`timescale 1ns/1ps

module tbCpu;

    typedef struct packed {
        cpuPkg::wordT pc;
        cpuPkg::regAddrT num;
        cpuPkg::wordT value;
    } retireT;

    logic clk;
    logic reset;
    cpuPkg::wordT instAddr;
    logic instReadEn;
    cpuPkg::wordT instRdata;
    logic instValid;
    cpuPkg::wordT dataAddr;
    logic dataRead;
    logic dataWrite;
    cpuPkg::wordT dataWdata;
    cpuPkg::wordT dataRdata;
    logic dataValid;
    cpuPkg::wordT wbPc;
    logic [3:0] wbWen;
    cpuPkg::regAddrT wbNum;
    cpuPkg::wordT wbData;

    cpuPkg::wordT imem [0:63];
    cpuPkg::wordT dmem [0:63];
    retireT expected[$];
    string testNames[$];
    cpuPkg::wordT progPc;
    int seed = 80;
    int instWait;
    int dataWait;
    logic instArmed;
    logic dataArmed;
    int checked = 0;
    int unsigned errors = 0;
    int unsigned cycles = 0;
    // About 30 instructions at up to 5 cycles each, load and store waits, margin
    int unsigned cycleLimit = 400;

    cpuCore uut (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instReadEn(instReadEn),
        .instRdata(instRdata),
        .instValid(instValid),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .wbPc(wbPc),
        .wbWen(wbWen),
        .wbNum(wbNum),
        .wbData(wbData)
    );

    always #4 clk = ~clk;

    function automatic cpuPkg::wordT rType(input logic [5:0] funct, input int rs, input int rt,
                                           input int rd);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic cpuPkg::wordT iType(input logic [5:0] op, input int rs, input int rt,
                                           input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic cpuPkg::wordT jType(input logic [5:0] op, input cpuPkg::wordT target);
        return {op, target[27:2]};
    endfunction

    function automatic int drawLatency();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    task automatic placeInstr(input cpuPkg::wordT word);
        imem[progPc[7:2]] = word;
        progPc = progPc + 32'd4;
    endtask

    task automatic expectWrite(input string name, input cpuPkg::wordT pc, input int num,
                               input cpuPkg::wordT value);
        retireT entry;
        entry.pc = pc;
        entry.num = num[4:0];
        entry.value = value;
        expected.push_back(entry);
        testNames.push_back(name);
    endtask

    task automatic reportMismatch(input string name, input string field,
                                  input cpuPkg::wordT want, input cpuPkg::wordT got);
        errors++;
        $display("FAIL %s (%s): expected %h, actual %h", name, field, want, got);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0000_0000;
            dmem[i] = 32'hDA7A_0000 + i * 4;
        end
        progPc = 32'h0000_0000;
        placeInstr(iType(6'h09, 0, 1, 16'd5));           // 00 addiu r1, r0, 5
        placeInstr(iType(6'h09, 1, 2, 16'd7));           // 04 addiu r2, r1, 7
        placeInstr(rType(6'h21, 1, 2, 3));               // 08 addu r3, r1, r2
        placeInstr(rType(6'h23, 3, 1, 4));               // 0c subu r4, r3, r1
        placeInstr(iType(6'h0f, 0, 5, 16'h1234));        // 10 lui r5
        placeInstr(iType(6'h0d, 5, 5, 16'h5678));        // 14 ori r5, r5
        placeInstr(rType(6'h24, 5, 3, 6));               // 18 and r6, r5, r3
        placeInstr(rType(6'h25, 6, 1, 7));               // 1c or r7, r6, r1
        placeInstr(rType(6'h2a, 4, 3, 8));               // 20 slt r8, r4, r3
        placeInstr(iType(6'h09, 0, 9, 16'hFFFD));        // 24 addiu r9, r0, -3
        placeInstr(rType(6'h2a, 9, 1, 10));              // 28 slt r10, r9, r1
        placeInstr(iType(6'h2b, 0, 5, 16'd16));          // 2c sw r5, 16(r0)
        placeInstr(iType(6'h23, 0, 11, 16'd16));         // 30 lw r11, 16(r0)
        placeInstr(rType(6'h21, 11, 1, 12));             // 34 addu r12, r11, r1
        placeInstr(iType(6'h04, 1, 1, 16'd3));           // 38 beq to 48
        placeInstr(iType(6'h09, 0, 13, 16'd1));          // 3c delay slot
        placeInstr(iType(6'h09, 0, 14, 16'h0077));       // 40 skipped
        placeInstr(iType(6'h09, 0, 14, 16'h0066));       // 44 skipped
        placeInstr(iType(6'h05, 1, 1, 16'd10));          // 48 bne, not taken
        placeInstr(iType(6'h09, 0, 15, 16'd2));          // 4c delay slot
        placeInstr(iType(6'h09, 0, 16, 16'd3));          // 50 fall-through
        placeInstr(jType(6'h03, 32'h0000_0068));         // 54 jal 68
        placeInstr(iType(6'h09, 0, 17, 16'd4));          // 58 delay slot
        placeInstr(rType(6'h21, 18, 31, 19));            // 5c return point
        placeInstr(jType(6'h02, 32'h0000_0060));         // 60 j 60
        placeInstr(rType(6'h21, 1, 1, 0));               // 64 addu r0, never reported
        placeInstr(iType(6'h09, 0, 18, 16'h0040));       // 68 subroutine
        placeInstr(rType(6'h08, 31, 0, 0));              // 6c jr r31
        placeInstr(iType(6'h09, 31, 20, 16'd0));         // 70 delay slot
        placeInstr(iType(6'h09, 0, 21, 16'd9));          // 74 never reached
    endtask

    // Register writes in retire order, from MIPS semantics
    task automatic buildTable();
        expectWrite("addiu", 32'h00, 1, 32'd5);
        expectWrite("addiu forward from execute", 32'h04, 2, 32'd12);
        expectWrite("addu two forwards", 32'h08, 3, 32'd17);
        expectWrite("subu", 32'h0c, 4, 32'd12);
        expectWrite("lui", 32'h10, 5, 32'h1234_0000);
        expectWrite("ori", 32'h14, 5, 32'h1234_5678);
        expectWrite("and", 32'h18, 6, 32'h0000_0010);
        expectWrite("or", 32'h1c, 7, 32'h0000_0015);
        expectWrite("slt", 32'h20, 8, 32'd1);
        expectWrite("addiu negative", 32'h24, 9, 32'hFFFF_FFFD);
        expectWrite("slt signed", 32'h28, 10, 32'd1);
        expectWrite("lw after sw", 32'h30, 11, 32'h1234_5678);
        expectWrite("use right after load", 32'h34, 12, 32'h1234_567D);
        expectWrite("beq delay slot", 32'h3c, 13, 32'd1);
        expectWrite("bne delay slot", 32'h4c, 15, 32'd2);
        expectWrite("bne fall-through", 32'h50, 16, 32'd3);
        expectWrite("jal link", 32'h54, 31, 32'h0000_005C);
        expectWrite("jal delay slot", 32'h58, 17, 32'd4);
        expectWrite("subroutine body", 32'h68, 18, 32'h0000_0040);
        expectWrite("jr delay slot", 32'h70, 20, 32'h0000_005C);
        expectWrite("after jr return", 32'h5c, 19, 32'h0000_009C);
    endtask

    // Both memories answer after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (reset) begin
            instValid <= 1'b0;
            dataValid <= 1'b0;
            instArmed = 1'b0;
            dataArmed = 1'b0;
        end else begin
            if (instValid) begin
                instValid <= 1'b0;
            end else if (instReadEn) begin
                if (!instArmed) begin
                    instWait = drawLatency();
                    instArmed = 1'b1;
                end
                if (instWait == 0) begin
                    instValid <= 1'b1;
                    instRdata <= imem[instAddr[7:2]];
                    instArmed = 1'b0;
                end else begin
                    instWait--;
                end
            end
            if (dataValid) begin
                dataValid <= 1'b0;
            end else if (dataRead || dataWrite) begin
                if (!dataArmed) begin
                    dataWait = drawLatency();
                    dataArmed = 1'b1;
                end
                if (dataWait == 0) begin
                    dataValid <= 1'b1;
                    dataArmed = 1'b0;
                    if (dataWrite) begin
                        dmem[dataAddr[7:2]] <= dataWdata;
                    end else begin
                        dataRdata <= dmem[dataAddr[7:2]];
                    end
                end else begin
                    dataWait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && wbWen != 4'h0) begin
            assert (checked < expected.size()) else begin
                errors++;
                $display("Unexpected write to r%0d at pc %h after the last expected write",
                         wbNum, wbPc);
            end
            if (checked < expected.size()) begin
                assert (wbWen == 4'hf) else begin
                    errors++;
                    $display("Partial write enable %b at pc %h", wbWen, wbPc);
                end
                assert (wbPc == expected[checked].pc)
                    else reportMismatch(testNames[checked], "pc", expected[checked].pc, wbPc);
                assert (wbNum == expected[checked].num)
                    else reportMismatch(testNames[checked], "register",
                                        {27'd0, expected[checked].num}, {27'd0, wbNum});
                assert (wbData == expected[checked].value)
                    else reportMismatch(testNames[checked], "value",
                                        expected[checked].value, wbData);
                checked++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycleLimit) begin
            $display("Timeout after %0d cycles, %0d of %0d writes retired",
                     cycles, checked, expected.size());
            $display("Errors: %0d value, %0d protocol", errors, uut.protocolChecks.failCount);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instRdata = '0;
        instValid = 1'b0;
        dataRdata = '0;
        dataValid = 1'b0;
        loadProgram();
        buildTable();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait (checked == expected.size());
        // Keep watching the jump loop for stray writes
        repeat (20) @(posedge clk);
        $display("Errors: %0d value, %0d protocol", errors, uut.protocolChecks.failCount);
        if (errors == 0 && uut.protocolChecks.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- compile.f
cpuPkg.sv
fetchUnit.sv
registerFile.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
cpuCore.sv
cpuCore_assertions.sv
tbCpu.sv

//--- Makefile
TOP = tbCpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
